// File: verilog/otp_part_pkg.sv
package otp_part_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NumParts      = 3;
  localparam int unsigned PartIdxWidth  = $clog2(NumParts);
  // Byte address of the whole fuse array
  localparam int unsigned ByteAddrWidth = 10;
  // 32-bit word address, used on the partition and macro side
  localparam int unsigned WordAddrWidth = 8;
  // Digest and two-word macro read
  localparam int unsigned DigestWidth   = 64;

  //////////////////////////////
  // Error codes
  //////////////////////////////

  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroEccCorrError   = 3'h1,
    MacroEccUncorrError = 3'h2,
    AccessError         = 3'h3,
    FsmStateError       = 3'h4
  } otp_err_e;

  //////////////////////////////
  // Partition table
  //////////////////////////////

  typedef struct packed {
    logic [ByteAddrWidth-1:0] offset;
    logic [ByteAddrWidth:0]   size;
    logic                     has_digest;
    // Digest != 0 locks reads
    logic                     digest_read_lock;
  } part_info_t;

  // Digest sits in the last 8 bytes of a partition
  localparam part_info_t PartInfo [NumParts] = '{
    '{offset: 10'h000, size: 11'h100, has_digest: 1'b0, digest_read_lock: 1'b0},
    '{offset: 10'h100, size: 11'h100, has_digest: 1'b1, digest_read_lock: 1'b0},
    '{offset: 10'h200, size: 11'h100, has_digest: 1'b1, digest_read_lock: 1'b1}
  };

  //////////////////////////////
  // Bus and macro structs
  //////////////////////////////

  // Wishbone classic, read only in practice
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [ByteAddrWidth-1:0] adr;
    logic [31:0]              dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                     req;
    logic [WordAddrWidth-1:0] addr;
  } part_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } part_rsp_t;

  // Size 0 reads one word, size 1 reads two
  typedef struct packed {
    logic                     req;
    logic [WordAddrWidth-1:0] addr;
    logic                     size;
  } otp_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [DigestWidth-1:0] rdata;
    otp_err_e               err;
  } otp_rsp_t;

endpackage

// File: verilog/otp_part_unbuf.sv
`timescale 1ns/1ps

module otp_part_unbuf #(
  parameter otp_part_pkg::part_info_t Info = otp_part_pkg::PartInfo[0]
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Init pulse, once after reset
  input  logic                                 init_req_i,
  output logic                                 init_done_o,
  // Global escalation, locks the partition for good
  input  logic                                 escalate_i,
  // Runtime read lock
  input  logic                                 read_lock_i,
  output otp_part_pkg::otp_err_e               error_o,
  output logic [otp_part_pkg::DigestWidth-1:0] digest_o,
  // Bus side
  input  otp_part_pkg::part_req_t              bus_req_i,
  output otp_part_pkg::part_rsp_t              bus_rsp_o,
  // Macro side
  output otp_part_pkg::otp_req_t               otp_req_o,
  input  otp_part_pkg::otp_rsp_t               otp_rsp_i
);

  typedef enum logic [2:0] {
    ResetSt,
    InitSt,
    InitWaitSt,
    IdleSt,
    ReadSt,
    ReadWaitSt,
    ErrorSt
  } state_e;

  state_e state_d, state_q;
  otp_part_pkg::otp_err_e error_d, error_q;
  logic pending_err_d, pending_err_q;
  logic digest_sel;
  logic digest_en;
  logic read_locked;
  logic [otp_part_pkg::WordAddrWidth-1:0] addr_q;
  logic [otp_part_pkg::WordAddrWidth-1:0] digest_word_addr;
  logic [otp_part_pkg::DigestWidth-1:0] digest_q;

  // Last two words of the partition
  assign digest_word_addr = Info.offset[otp_part_pkg::ByteAddrWidth-1:2] +
                            Info.size[otp_part_pkg::ByteAddrWidth-1:2] - 8'd2;

  // Runtime lock, or digest lock once a digest was written
  assign read_locked = read_lock_i || (Info.digest_read_lock && (digest_q != '0));

  assign error_o  = error_q;
  assign digest_o = digest_q;

  //////////////////////////////
  // Partition FSM
  //////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    error_d       = error_q;
    pending_err_d = 1'b0;
    digest_en     = 1'b0;
    digest_sel    = 1'b1;
    init_done_o   = 1'b0;
    otp_req_o     = '0;
    bus_rsp_o     = '0;

    unique case (state_q)
      // Wait for the init pulse, nothing to fetch without a digest
      ResetSt: begin
        if (init_req_i) begin
          state_d = Info.has_digest ? InitSt : IdleSt;
        end
      end
      // Fetch both digest words in one macro access
      InitSt: begin
        otp_req_o.req = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = InitWaitSt;
        end
      end
      InitWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          digest_en = 1'b1;
          if (otp_rsp_i.err inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError}) begin
            state_d = IdleSt;
            error_d = otp_rsp_i.err;
          end else begin
            state_d = ErrorSt;
            error_d = otp_rsp_i.err;
          end
        end
      end
      // Any new access clears a soft error
      IdleSt: begin
        init_done_o = 1'b1;
        if (bus_req_i.req) begin
          bus_rsp_o.gnt = 1'b1;
          error_d       = otp_part_pkg::NoError;
          state_d       = ReadSt;
        end
      end
      // Refused reads answer at once and are not fatal
      ReadSt: begin
        init_done_o = 1'b1;
        if (read_locked) begin
          bus_rsp_o.rvalid = 1'b1;
          bus_rsp_o.err    = 1'b1;
          error_d          = otp_part_pkg::AccessError;
          state_d          = IdleSt;
        end else begin
          otp_req_o.req = 1'b1;
          digest_sel    = 1'b0;
          if (otp_rsp_i.gnt) begin
            state_d = ReadWaitSt;
          end
        end
      end
      ReadWaitSt: begin
        init_done_o = 1'b1;
        digest_sel  = 1'b0;
        if (otp_rsp_i.rvalid) begin
          bus_rsp_o.rvalid = 1'b1;
          if (otp_rsp_i.err inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError}) begin
            error_d = otp_rsp_i.err;
            state_d = IdleSt;
          end else begin
            bus_rsp_o.err = 1'b1;
            error_d       = otp_rsp_i.err;
            state_d       = ErrorSt;
          end
        end
      end
      // Terminal, every granted request gets err a cycle later
      ErrorSt: begin
        if (error_q == otp_part_pkg::NoError) begin
          error_d = otp_part_pkg::FsmStateError;
        end
        if (pending_err_q) begin
          bus_rsp_o.rvalid = 1'b1;
          bus_rsp_o.err    = 1'b1;
        end else if (bus_req_i.req) begin
          bus_rsp_o.gnt = 1'b1;
          pending_err_d = 1'b1;
        end
      end
      default: begin
        state_d = ErrorSt;
      end
    endcase

    // Escalation overrides whatever the FSM decided
    if (escalate_i) begin
      state_d = ErrorSt;
      if (state_q != ErrorSt) begin
        error_d = otp_part_pkg::FsmStateError;
      end
      // An access already granted still needs its answer
      if ((bus_rsp_o.gnt || state_q inside {ReadSt, ReadWaitSt}) && !bus_rsp_o.rvalid) begin
        pending_err_d = 1'b1;
      end
    end

    otp_req_o.addr  = digest_sel ? digest_word_addr : addr_q;
    otp_req_o.size  = digest_sel;
    // no data goes out with an error
    bus_rsp_o.rdata = (bus_rsp_o.rvalid && !bus_rsp_o.err) ? otp_rsp_i.rdata[31:0] : '0;
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= ResetSt;
      error_q       <= otp_part_pkg::NoError;
      pending_err_q <= 1'b0;
      digest_q      <= '0;
    end else begin
      state_q       <= state_d;
      error_q       <= error_d;
      pending_err_q <= pending_err_d;
      if (digest_en) begin
        digest_q <= otp_rsp_i.rdata;
      end
    end
  end

  // Word address of the granted access
  always_ff @(posedge clk_i) begin : p_addr
    if (bus_rsp_o.gnt) begin
      addr_q <= bus_req_i.addr;
    end
  end

endmodule

// File: verilog/otp_bus_router.sv
`timescale 1ns/1ps

module otp_bus_router (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  otp_part_pkg::wb_req_t   wb_req_i,
  output otp_part_pkg::wb_rsp_t   wb_rsp_o,
  output otp_part_pkg::part_req_t part_req_o [otp_part_pkg::NumParts],
  input  otp_part_pkg::part_rsp_t part_rsp_i [otp_part_pkg::NumParts]
);

  typedef enum logic [1:0] {
    IdleSt,
    RequestSt,
    WaitSt,
    RespondSt
  } state_e;

  state_e state_d, state_q;
  logic hit;
  logic [otp_part_pkg::PartIdxWidth-1:0] hit_idx;
  logic [otp_part_pkg::PartIdxWidth-1:0] idx_q;
  logic [otp_part_pkg::WordAddrWidth-1:0] addr_q;
  logic err_q;
  logic [31:0] rdata_q;
  otp_part_pkg::part_rsp_t sel_rsp;

  // Partition lookup from the table ranges
  always_comb begin : p_decode
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < otp_part_pkg::NumParts; i++) begin
      if (({1'b0, wb_req_i.adr} >= {1'b0, otp_part_pkg::PartInfo[i].offset}) &&
          ({1'b0, wb_req_i.adr} < ({1'b0, otp_part_pkg::PartInfo[i].offset} +
                                   otp_part_pkg::PartInfo[i].size))) begin
        hit     = 1'b1;
        hit_idx = otp_part_pkg::PartIdxWidth'(i);
      end
    end
  end

  // Response of the partition in use, and requests out
  always_comb begin : p_route
    sel_rsp = '0;
    for (int i = 0; i < otp_part_pkg::NumParts; i++) begin
      part_req_o[i].req  = (state_q == RequestSt) && (idx_q == otp_part_pkg::PartIdxWidth'(i));
      part_req_o[i].addr = addr_q;
      if (idx_q == otp_part_pkg::PartIdxWidth'(i)) begin
        sel_rsp = part_rsp_i[i];
      end
    end
  end

  always_comb begin : p_fsm
    state_d = state_q;
    unique case (state_q)
      IdleSt:    if (wb_req_i.cyc && wb_req_i.stb) state_d = (wb_req_i.we || !hit) ? RespondSt
                                                                                   : RequestSt;
      RequestSt: if (sel_rsp.gnt) state_d = WaitSt;
      WaitSt:    if (sel_rsp.rvalid) state_d = RespondSt;
      default:   state_d = IdleSt;
    endcase
  end

  // One-cycle ack or err
  assign wb_rsp_o.ack = (state_q == RespondSt) && !err_q;
  assign wb_rsp_o.err = (state_q == RespondSt) && err_q;
  assign wb_rsp_o.dat = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= IdleSt;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (state_q == IdleSt) begin
      idx_q   <= hit_idx;
      addr_q  <= wb_req_i.adr[otp_part_pkg::ByteAddrWidth-1:2];
      // Writes and holes are refused here
      err_q   <= wb_req_i.we || !hit;
      rdata_q <= '0;
    end else if (state_q == WaitSt && sel_rsp.rvalid) begin
      err_q   <= sel_rsp.err;
      rdata_q <= sel_rsp.rdata;
    end
  end

endmodule

// File: verilog/otp_macro_arbiter.sv
`timescale 1ns/1ps

module otp_macro_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  otp_part_pkg::otp_req_t part_req_i [otp_part_pkg::NumParts],
  output otp_part_pkg::otp_rsp_t part_rsp_o [otp_part_pkg::NumParts],
  output otp_part_pkg::otp_req_t otp_req_o,
  input  otp_part_pkg::otp_rsp_t otp_rsp_i
);

  logic busy_q;
  logic sel_valid;
  logic [otp_part_pkg::PartIdxWidth-1:0] sel_idx;
  logic [otp_part_pkg::PartIdxWidth-1:0] owner_q;

  //////////////////////////////
  // Fixed priority pick
  //////////////////////////////

  // Lowest index wins, so scan downwards
  always_comb begin : p_select
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = otp_part_pkg::NumParts - 1; i >= 0; i--) begin
      if (part_req_i[i].req) begin
        sel_valid = 1'b1;
        sel_idx   = otp_part_pkg::PartIdxWidth'(i);
      end
    end
  end

  // Nothing new goes out while a read is in flight
  always_comb begin : p_fwd
    otp_req_o = '0;
    for (int i = 0; i < otp_part_pkg::NumParts; i++) begin
      if (!busy_q && sel_valid && (sel_idx == otp_part_pkg::PartIdxWidth'(i))) begin
        otp_req_o = part_req_i[i];
      end
    end
  end

  //////////////////////////////
  // Response fan-out
  //////////////////////////////

  // gnt goes to the selected requester, the rest to the owner
  always_comb begin : p_fanout
    for (int i = 0; i < otp_part_pkg::NumParts; i++) begin
      part_rsp_o[i] = '0;
      if (!busy_q && sel_valid && (sel_idx == otp_part_pkg::PartIdxWidth'(i))) begin
        part_rsp_o[i].gnt = otp_rsp_i.gnt;
      end
      if (busy_q && (owner_q == otp_part_pkg::PartIdxWidth'(i))) begin
        part_rsp_o[i].rvalid = otp_rsp_i.rvalid;
        part_rsp_o[i].rdata  = otp_rsp_i.rdata;
        part_rsp_o[i].err    = otp_rsp_i.err;
      end
    end
  end

  // Owner held from gnt until rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_owner
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
    end else if (!busy_q) begin
      if (sel_valid && otp_rsp_i.gnt) begin
        busy_q  <= 1'b1;
        owner_q <= sel_idx;
      end
    end else if (otp_rsp_i.rvalid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// File: verilog/otp_part_top.sv
`timescale 1ns/1ps

module otp_part_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 init_req_i,
  input  logic                                 escalate_i,
  input  logic [otp_part_pkg::NumParts-1:0]    read_lock_i,
  // Wishbone slave
  input  otp_part_pkg::wb_req_t                wb_req_i,
  output otp_part_pkg::wb_rsp_t                wb_rsp_o,
  output logic                                 init_done_o,
  output otp_part_pkg::otp_err_e               part_error_o [otp_part_pkg::NumParts],
  output logic [otp_part_pkg::DigestWidth-1:0] digest_o [otp_part_pkg::NumParts],
  // Fuse macro
  output otp_part_pkg::otp_req_t               otp_req_o,
  input  otp_part_pkg::otp_rsp_t               otp_rsp_i
);

  otp_part_pkg::part_req_t part_req [otp_part_pkg::NumParts];
  otp_part_pkg::part_rsp_t part_rsp [otp_part_pkg::NumParts];
  otp_part_pkg::otp_req_t  part_otp_req [otp_part_pkg::NumParts];
  otp_part_pkg::otp_rsp_t  part_otp_rsp [otp_part_pkg::NumParts];
  logic [otp_part_pkg::NumParts-1:0] part_done;

  // Ready only when every partition is
  assign init_done_o = &part_done;

  otp_bus_router i_otp_bus_router (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .part_req_o (part_req),
    .part_rsp_i (part_rsp)
  );

  // One partition per table entry
  for (genvar i = 0; i < otp_part_pkg::NumParts; i++) begin : gen_parts
    otp_part_unbuf #(
      .Info (otp_part_pkg::PartInfo[i])
    ) i_otp_part_unbuf (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .init_req_i  (init_req_i),
      .init_done_o (part_done[i]),
      .escalate_i  (escalate_i),
      .read_lock_i (read_lock_i[i]),
      .error_o     (part_error_o[i]),
      .digest_o    (digest_o[i]),
      .bus_req_i   (part_req[i]),
      .bus_rsp_o   (part_rsp[i]),
      .otp_req_o   (part_otp_req[i]),
      .otp_rsp_i   (part_otp_rsp[i])
    );
  end

  otp_macro_arbiter i_otp_macro_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .part_req_i (part_otp_req),
    .part_rsp_o (part_otp_rsp),
    .otp_req_o  (otp_req_o),
    .otp_rsp_i  (otp_rsp_i)
  );

endmodule

// File: verification/otp_macro_model.sv
`timescale 1ns/1ps

module otp_macro_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  otp_part_pkg::otp_req_t otp_req_i,
  output otp_part_pkg::otp_rsp_t otp_rsp_o,
  // One-cycle pulse arms an error code for the next response
  input  logic                   inj_en_i,
  input  otp_part_pkg::otp_err_e inj_err_i
);

  logic busy_q;
  logic size_q;
  logic [1:0] delay_q;
  logic [otp_part_pkg::WordAddrWidth-1:0] addr_q;
  otp_part_pkg::otp_err_e inj_q;

  // Word w holds w in both 16-bit halves
  function automatic logic [31:0] word_at(input logic [7:0] w);
    return {8'h00, w, 8'h00, w};
  endfunction

  //////////////////////////////
  // Fuse access timing
  //////////////////////////////

  // gnt one cycle after req and rvalid two cycles after gnt
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_macro
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      size_q    <= 1'b0;
      delay_q   <= 2'd0;
      addr_q    <= '0;
      inj_q     <= otp_part_pkg::NoError;
      otp_rsp_o <= '0;
    end else begin
      otp_rsp_o <= '0;
      if (!busy_q) begin
        if (otp_req_i.req) begin
          busy_q        <= 1'b1;
          size_q        <= otp_req_i.size;
          addr_q        <= otp_req_i.addr;
          delay_q       <= 2'd2;
          otp_rsp_o.gnt <= 1'b1;
        end
      end else if (delay_q == 2'd1) begin
        busy_q           <= 1'b0;
        otp_rsp_o.rvalid <= 1'b1;
        // Upper word only on a two-word read
        otp_rsp_o.rdata  <= {(size_q ? word_at(addr_q + 8'd1) : 32'h0), word_at(addr_q)};
        // Armed error goes out once
        otp_rsp_o.err    <= inj_q;
        inj_q            <= otp_part_pkg::NoError;
      end
      if (busy_q) begin
        delay_q <= delay_q - 2'd1;
      end
      if (inj_en_i) begin
        inj_q <= inj_err_i;
      end
    end
  end

endmodule

// File: verification/otp_part_tb.sv
`timescale 1ns/1ps

module otp_part_tb;

  localparam int unsigned TimeoutCycles = 3000;
  // Reads per partition in P0 and P1
  localparam int unsigned NumRandReads  = 80;

  logic clk_i;
  logic rst_ni;
  logic init_req;
  logic escalate;
  logic [otp_part_pkg::NumParts-1:0] read_lock;
  otp_part_pkg::wb_req_t wb_req;
  otp_part_pkg::wb_rsp_t wb_rsp;
  logic init_done;
  otp_part_pkg::otp_err_e part_error [otp_part_pkg::NumParts];
  logic [otp_part_pkg::DigestWidth-1:0] digest [otp_part_pkg::NumParts];
  otp_part_pkg::otp_req_t otp_req;
  otp_part_pkg::otp_rsp_t otp_rsp;
  logic inj_en;
  otp_part_pkg::otp_err_e inj_err;
  int unsigned cycle_cnt = 0;

  //////////////////////////////
  // Clock, DUT and fuse macro
  //////////////////////////////

  initial begin : p_clk
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  otp_part_top i_otp_part_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_req_i   (init_req),
    .escalate_i   (escalate),
    .read_lock_i  (read_lock),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .init_done_o  (init_done),
    .part_error_o (part_error),
    .digest_o     (digest),
    .otp_req_o    (otp_req),
    .otp_rsp_i    (otp_rsp)
  );

  otp_macro_model i_otp_macro_model (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .otp_req_i (otp_req),
    .otp_rsp_o (otp_rsp),
    .inj_en_i  (inj_en),
    .inj_err_i (inj_err)
  );

  // Hard stop well past the expected run length
  always @(posedge clk_i) begin : p_watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Verification failed");
      $fatal(1, "Simulation stopped by the watchdog");
    end
  end

  //////////////////////////////
  // Expected fuse content
  //////////////////////////////

  function automatic logic [31:0] fuse_word(input logic [7:0] w);
    return {8'h00, w, 8'h00, w};
  endfunction

  // Two-word read with word w+1 on top
  function automatic logic [63:0] fuse_dword(input logic [7:0] w);
    return {fuse_word(w + 8'd1), fuse_word(w)};
  endfunction

  task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  //////////////////////////////
  // Wishbone master
  //////////////////////////////

  // Holds cyc and stb until ack or err and samples 1 ns after the edge
  task automatic bus_access(input logic [9:0] adr, input logic we,
                            output logic [31:0] rdata, output logic failed);
    @(posedge clk_i);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = '0;
    do begin
      @(posedge clk_i);
      #1;
    end while (!(wb_rsp.ack || wb_rsp.err));
    compare(64'(wb_rsp.ack && wb_rsp.err), 64'd0, "ack and err together");
    rdata  = wb_rsp.dat;
    failed = wb_rsp.err;
    wb_req = '0;
  endtask

  task automatic read_expect(input logic [9:0] adr, input logic [31:0] exp_data);
    logic [31:0] data;
    logic failed;
    bus_access(adr, 1'b0, data, failed);
    compare(64'(failed), 64'd0, $sformatf("err on read of 0x%03h", adr));
    compare(64'(data), 64'(exp_data), $sformatf("data of 0x%03h", adr));
  endtask

  task automatic access_refused(input logic [9:0] adr, input logic we);
    logic [31:0] data;
    logic failed;
    bus_access(adr, we, data, failed);
    compare(64'(failed), 64'd1, $sformatf("no err on access to 0x%03h, we %0b", adr, we));
  endtask

  // Arms the macro error for its next response
  task automatic inject_error(input otp_part_pkg::otp_err_e code);
    @(posedge clk_i);
    #1;
    inj_en  = 1'b1;
    inj_err = code;
    @(posedge clk_i);
    #1;
    inj_en  = 1'b0;
    inj_err = otp_part_pkg::NoError;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic init_partitions();
    compare(64'(init_done), 64'd0, "init_done before init");
    @(posedge clk_i);
    #1 init_req = 1'b1;
    @(posedge clk_i);
    #1 init_req = 1'b0;
    while (!init_done) begin
      @(posedge clk_i);
      #1;
    end
    compare(digest[0], 64'd0, "P0 digest");
    // Digests sit in the last 8 bytes at 0x1F8 and 0x2F8
    compare(digest[1], fuse_dword(8'h7E), "P1 digest");
    compare(digest[2], fuse_dword(8'hBE), "P2 digest");
    for (int i = 0; i < otp_part_pkg::NumParts; i++) begin
      compare(64'(part_error[i]), 64'(otp_part_pkg::NoError),
              $sformatf("P%0d error after init", i));
    end
  endtask

  task automatic random_reads();
    logic [7:0] w;
    for (int n = 0; n < NumRandReads; n++) begin
      w = 8'($urandom % 64);
      read_expect({w, 2'b00}, fuse_word(w));
      // P1 words start at 0x40
      w = 8'h40 + 8'($urandom % 64);
      read_expect({w, 2'b00}, fuse_word(w));
    end
  endtask

  task automatic access_refusals();
    // P2 has a written digest and a digest read lock
    access_refused(10'h2F0, 1'b0);
    compare(64'(part_error[2]), 64'(otp_part_pkg::AccessError), "P2 error on lock");
    read_lock[0] = 1'b1;
    access_refused(10'h010, 1'b0);
    compare(64'(part_error[0]), 64'(otp_part_pkg::AccessError), "P0 error on lock");
    read_lock[0] = 1'b0;
    access_refused(10'h020, 1'b1);
    // Unmapped space
    access_refused(10'h300, 1'b0);
    access_refused(10'h3FC, 1'b0);
    read_expect(10'h024, fuse_word(8'h09));
    compare(64'(part_error[0]), 64'(otp_part_pkg::NoError), "P0 error after clean read");
  endtask

  task automatic correctable_error();
    inject_error(otp_part_pkg::MacroEccCorrError);
    read_expect(10'h1A0, fuse_word(8'h68));
    compare(64'(part_error[1]), 64'(otp_part_pkg::MacroEccCorrError), "P1 soft error");
  endtask

  task automatic uncorrectable_error();
    inject_error(otp_part_pkg::MacroEccUncorrError);
    access_refused(10'h140, 1'b0);
    compare(64'(part_error[1]), 64'(otp_part_pkg::MacroEccUncorrError), "P1 fatal error");
    access_refused(10'h150, 1'b0);
    access_refused(10'h1F8, 1'b0);
    compare(64'(part_error[1]), 64'(otp_part_pkg::MacroEccUncorrError), "P1 error kept");
    // Other partitions are unaffected
    read_expect(10'h0FC, fuse_word(8'h3F));
  endtask

  task automatic escalation();
    escalate = 1'b1;
    @(posedge clk_i);
    #1;
    compare(64'(init_done), 64'd0, "init_done under escalation");
    compare(64'(part_error[0]), 64'(otp_part_pkg::FsmStateError), "P0 escalated");
    compare(64'(part_error[1]), 64'(otp_part_pkg::MacroEccUncorrError), "P1 escalated");
    compare(64'(part_error[2]), 64'(otp_part_pkg::FsmStateError), "P2 escalated");
    access_refused(10'h000, 1'b0);
    access_refused(10'h104, 1'b0);
    access_refused(10'h208, 1'b0);
  endtask

  initial begin : p_main
    rst_ni    = 1'b0;
    init_req  = 1'b0;
    escalate  = 1'b0;
    read_lock = '0;
    wb_req    = '0;
    inj_en    = 1'b0;
    inj_err   = otp_part_pkg::NoError;
    void'($urandom(44));
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    init_partitions();
    random_reads();
    access_refusals();
    correctable_error();
    uncorrectable_error();
    escalation();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: compile.f
verilog/otp_part_pkg.sv
verilog/otp_part_unbuf.sv
verilog/otp_bus_router.sv
verilog/otp_macro_arbiter.sv
verilog/otp_part_top.sv
verification/otp_macro_model.sv
verification/otp_part_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= otp_part_tb
RTL_TOP   ?= otp_part_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
